// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic CLK,
    output logic RST
);

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Reset held over the first 10 rising edges
    initial
    begin
        RST = 1'b1;
        repeat (10) @(posedge CLK);
        #1 RST = 1'b0;
    end

endmodule

// File: bench/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;
    import exu_pkg::*;

    // Tests need about 300 cycles
    localparam int TIMEOUT_CYCLES = 2000;
    localparam xword_t SIGN_BIT = 64'h8000_0000_0000_0000;

    logic CLK;
    logic RST;
    logic in_valid;
    logic in_ready;
    logic mem_ready;
    alu_op_t alu_op;
    logic op_32;
    xword_t a;
    xword_t b;
    ctrl_kind_t ctrl_kind;
    br_cond_t br_cond;
    xword_t cmp1;
    xword_t cmp2;
    xword_t target_base;
    xword_t target_offset;
    xword_t pc;
    xword_t next_pc;
    mem_op_t mem_op_in;
    mem_size_t mem_size_in;
    logic out_valid;
    xword_t wb_data;
    mem_op_t mem_op;
    xword_t mem_addr;
    mem_size_t mem_size;
    logic ld_misaligned;
    logic st_misaligned;
    logic redirect;
    xword_t redirect_pc;
    logic target_misaligned;
    logic flush;

    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int cycle_count = 0;
    logic [31:0] rng_state = 32'h90b871fc;

    br_cond_t cond_list [6] = '{br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
    // Equal, less, greater, then pairs whose signs differ
    xword_t lhs_list [6] = '{64'd5, 64'd3, 64'd7, 64'hffff_ffff_ffff_ffff, 64'd1,
                             64'h8000_0000_0000_0000};
    xword_t rhs_list [6] = '{64'd5, 64'd7, 64'd3, 64'd1, 64'hffff_ffff_ffff_ffff,
                             64'h7fff_ffff_ffff_ffff};

    tb_clock clk_gen (
        .CLK (CLK),
        .RST (RST)
    );

    ex_stage #(
        .FLUSH_CYCLES (3)
    ) UUT (.*);

    always @(posedge CLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, tests did not finish", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic xword_t rand_xword();
        logic [31:0] hi;
        hi = next_random();
        return {hi, next_random()};
    endfunction

    function automatic xword_t alu_expect(alu_op_t op, logic w, xword_t x, xword_t y);
        xword_t r;
        logic [5:0] amt;
        amt = w ? {1'b0, x[4:0]} : x[5:0];
        case (op)
            alu_add:     r = x + y;
            alu_sub:     r = y - x;
            alu_sll:     r = y << amt;
            alu_srl:     r = (w ? {32'h0, y[31:0]} : y) >> amt;
            alu_sra:     r = $signed(w ? {{32{y[31]}}, y[31:0]} : y) >>> amt;
            alu_slt:     r = {63'b0, (y ^ SIGN_BIT) < (x ^ SIGN_BIT)};
            alu_sltu:    r = {63'b0, y < x};
            alu_xor:     r = x ^ y;
            alu_or:      r = x | y;
            alu_and:     r = x & y;
            alu_pass_a:  r = x;
            alu_pass_b:  r = y;
            alu_b_plus4: r = y + 64'd4;
            default:     r = 64'd0;
        endcase
        if (w && (op inside {alu_add, alu_sub, alu_sll, alu_srl, alu_sra}))
        begin
            r = {{32{r[31]}}, r[31:0]};
        end
        return r;
    endfunction

    function automatic logic cond_holds(br_cond_t c, xword_t x, xword_t y);
        xword_t xs;
        xword_t ys;
        // Sign bit flipped so signed order becomes unsigned order
        xs = x ^ SIGN_BIT;
        ys = y ^ SIGN_BIT;
        case (c)
            br_beq:  return x == y;
            br_bne:  return x != y;
            br_blt:  return xs < ys;
            br_bge:  return !(xs < ys);
            br_bltu: return x < y;
            br_bgeu: return !(x < y);
            default: return 1'b0;
        endcase
    endfunction

    task automatic compare_xword(input string name, input xword_t got, input xword_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_mem_op(input string name, input mem_op_t got, input mem_op_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_mem_size(input string name, input mem_size_t got,
                                    input mem_size_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    // Idle instruction, next_pc already correct
    task automatic clear_inputs();
        in_valid      = 1'b0;
        mem_ready     = 1'b1;
        alu_op        = alu_idle;
        op_32         = 1'b0;
        a             = 64'd0;
        b             = 64'd0;
        ctrl_kind     = ctrl_none;
        br_cond       = br_beq;
        cmp1          = 64'd0;
        cmp2          = 64'd0;
        target_base   = 64'd0;
        target_offset = 64'd0;
        pc            = 64'h0000_0000_8000_1000;
        next_pc       = 64'h0000_0000_8000_1004;
        mem_op_in     = mem_none;
        mem_size_in   = size_byte;
    endtask

    task automatic settle_flush();
        in_valid = 1'b0;
        while (flush)
        begin
            next_cycle();
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        $display("%-12s done, %0d errors", name, error_count - errors_before);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        int start;
        start = error_count;
        compare_bit("out_valid", out_valid, 1'b0);
        compare_bit("redirect", redirect, 1'b0);
        compare_bit("flush", flush, 1'b0);
        compare_mem_op("mem_op", mem_op, mem_none);
        finish_test("reset", start);
    endtask

    task automatic test_alu();
        int start;
        xword_t exp;
        start = error_count;
        for (int i = 0; i < 14; i++)
        begin
            for (int w = 0; w < 2; w++)
            begin
                repeat (4)
                begin
                    clear_inputs();
                    in_valid = 1'b1;
                    alu_op   = alu_op_t'(i[3:0]);
                    op_32    = w[0];
                    a        = rand_xword();
                    b        = rand_xword();
                    exp      = alu_expect(alu_op, op_32, a, b);
                    next_cycle();
                    compare_bit("out_valid", out_valid, 1'b1);
                    compare_xword("wb_data", wb_data, exp);
                    compare_bit("redirect", redirect, 1'b0);
                end
            end
        end
        finish_test("alu", start);
    endtask

    task automatic test_branches();
        int start;
        logic taken;
        xword_t target;
        start = error_count;
        for (int c = 0; c < 6; c++)
        begin
            for (int p = 0; p < 6; p++)
            begin
                clear_inputs();
                in_valid      = 1'b1;
                ctrl_kind     = ctrl_branch;
                br_cond       = cond_list[c];
                cmp1          = lhs_list[p];
                cmp2          = rhs_list[p];
                target_base   = pc;
                target_offset = 64'h40 + (rand_xword() & 64'hffc);
                target        = pc + target_offset;
                taken         = cond_holds(cond_list[c], lhs_list[p], rhs_list[p]);
                next_cycle();
                compare_bit("redirect", redirect, taken);
                compare_bit("flush", flush, taken);
                if (taken)
                begin
                    compare_xword("redirect_pc", redirect_pc, target);
                end
                settle_flush();
            end
        end
        finish_test("branches", start);
    endtask

    task automatic issue_jump(input xword_t offset, input logic predicted,
                              input logic misaligned);
        xword_t target;
        clear_inputs();
        in_valid      = 1'b1;
        ctrl_kind     = ctrl_jump;
        target_base   = rand_xword() & ~64'h3;
        target_offset = offset;
        target        = target_base + target_offset;
        if (predicted)
        begin
            next_pc = target;
        end
        next_cycle();
        compare_bit("redirect", redirect, !predicted);
        compare_bit("flush", flush, !predicted);
        if (!predicted)
        begin
            compare_xword("redirect_pc", redirect_pc, target);
            compare_bit("target_misaligned", target_misaligned, misaligned);
        end
        settle_flush();
    endtask

    task automatic test_jumps();
        int start;
        start = error_count;
        repeat (4)
        begin
            issue_jump(64'h80, 1'b1, 1'b0);
            issue_jump(64'h80, 1'b0, 1'b0);
            // Target low bits end in binary 10
            issue_jump(64'h82, 1'b0, 1'b1);
        end
        finish_test("jumps", start);
    endtask

    task automatic test_flush_window();
        int start;
        start = error_count;
        clear_inputs();
        in_valid      = 1'b1;
        ctrl_kind     = ctrl_jump;
        target_base   = rand_xword() & ~64'h3;
        target_offset = 64'h20;
        next_cycle();
        compare_bit("redirect", redirect, 1'b1);
        compare_bit("flush", flush, 1'b1);
        for (int i = 0; i < 3; i++)
        begin
            clear_inputs();
            in_valid  = 1'b1;
            alu_op    = alu_add;
            mem_op_in = mem_store;
            if (i == 1)
            begin
                ctrl_kind     = ctrl_jump;
                target_base   = 64'h4000;
                target_offset = 64'h10;
            end
            next_cycle();
            compare_bit("out_valid", out_valid, 1'b0);
            compare_mem_op("mem_op", mem_op, mem_none);
            compare_bit("redirect", redirect, 1'b0);
            compare_bit("flush", flush, i < 2);
        end
        clear_inputs();
        in_valid = 1'b1;
        alu_op   = alu_add;
        a        = rand_xword();
        b        = rand_xword();
        next_cycle();
        compare_bit("out_valid", out_valid, 1'b1);
        compare_xword("wb_data", wb_data, a + b);
        compare_bit("redirect", redirect, 1'b0);
        finish_test("flush", start);
    endtask

    task automatic test_memory();
        int start;
        xword_t sum;
        logic mis;
        start = error_count;
        for (int st = 0; st < 2; st++)
        begin
            for (int s = 0; s < 4; s++)
            begin
                repeat (4)
                begin
                    clear_inputs();
                    in_valid    = 1'b1;
                    mem_op_in   = (st == 1) ? mem_store : mem_load;
                    mem_size_in = mem_size_t'(s[1:0]);
                    a           = rand_xword();
                    b           = rand_xword();
                    sum         = a + b;
                    mis         = (sum & ((64'd1 << s) - 64'd1)) != 64'd0;
                    next_cycle();
                    compare_bit("out_valid", out_valid, 1'b1);
                    compare_mem_op("mem_op", mem_op, mem_op_in);
                    compare_xword("mem_addr", mem_addr, sum);
                    compare_mem_size("mem_size", mem_size, mem_size_in);
                    compare_bit("ld_misaligned", ld_misaligned, mis && (st == 0));
                    compare_bit("st_misaligned", st_misaligned, mis && (st == 1));
                end
            end
        end
        finish_test("memory", start);
    endtask

    task automatic test_backpressure();
        int start;
        xword_t first;
        xword_t a2;
        xword_t b2;
        start = error_count;
        clear_inputs();
        in_valid    = 1'b1;
        alu_op      = alu_add;
        mem_op_in   = mem_load;
        mem_size_in = size_double;
        // Sum ends in binary 100, misaligned for a double
        a           = rand_xword() & ~64'h7;
        b           = (rand_xword() & ~64'h7) | 64'h4;
        first       = a + b;
        next_cycle();
        compare_bit("out_valid", out_valid, 1'b1);
        compare_xword("wb_data", wb_data, first);
        compare_bit("ld_misaligned", ld_misaligned, 1'b1);
        // Pending store waits behind the memory stall
        a2          = rand_xword() & ~64'h1;
        b2          = rand_xword() | 64'h1;
        a           = a2;
        b           = b2;
        alu_op      = alu_xor;
        mem_op_in   = mem_store;
        mem_size_in = size_half;
        mem_ready   = 1'b0;
        repeat (5)
        begin
            next_cycle();
            compare_bit("in_ready", in_ready, 1'b0);
            compare_bit("out_valid", out_valid, 1'b1);
            compare_xword("wb_data", wb_data, first);
            compare_mem_op("mem_op", mem_op, mem_load);
            compare_xword("mem_addr", mem_addr, first);
            compare_mem_size("mem_size", mem_size, size_double);
            compare_bit("ld_misaligned", ld_misaligned, 1'b1);
        end
        mem_ready = 1'b1;
        next_cycle();
        compare_bit("in_ready", in_ready, 1'b1);
        compare_bit("out_valid", out_valid, 1'b1);
        compare_xword("wb_data", wb_data, a2 ^ b2);
        compare_mem_op("mem_op", mem_op, mem_store);
        compare_xword("mem_addr", mem_addr, a2 + b2);
        compare_mem_size("mem_size", mem_size, size_half);
        compare_bit("st_misaligned", st_misaligned, 1'b1);
        in_valid = 1'b0;
        finish_test("backpressure", start);
    endtask

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial
    begin
        clear_inputs();
        @(negedge RST);
        test_reset();
        test_alu();
        test_branches();
        test_jumps();
        test_flush_window();
        test_memory();
        test_backpressure();
        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic                accept,
    input  exu_pkg::ctrl_kind_t kind,
    input  exu_pkg::br_cond_t   cond,
    input  exu_pkg::xword_t     cmp1,
    input  exu_pkg::xword_t     cmp2,
    input  exu_pkg::xword_t     target_base,
    input  exu_pkg::xword_t     target_offset,
    input  exu_pkg::xword_t     pc,
    input  exu_pkg::xword_t     next_pc,
    redirect_if.resolver        rd
);
    import exu_pkg::*;

    logic   cond_true;
    logic   taken;
    xword_t target;
    xword_t correct_pc;

    always_comb
    begin
        case (cond)
            br_beq:  cond_true = cmp1 == cmp2;
            br_bne:  cond_true = cmp1 != cmp2;
            br_blt:  cond_true = $signed(cmp1) < $signed(cmp2);
            br_bge:  cond_true = $signed(cmp1) >= $signed(cmp2);
            br_bltu: cond_true = cmp1 < cmp2;
            br_bgeu: cond_true = cmp1 >= cmp2;
            default: cond_true = 1'b0;
        endcase
    end

    assign taken      = (kind == ctrl_jump) || ((kind == ctrl_branch) && cond_true);
    assign target     = target_base + target_offset;
    assign correct_pc = taken ? target : pc + XLEN'(4);

    assign rd.resolve           = accept;
    assign rd.mispredict        = next_pc != correct_pc;
    assign rd.new_pc            = correct_pc;
    // No compressed support, targets must be word aligned
    assign rd.target_misaligned = taken && (target[1:0] != 2'b00);

endmodule

// File: hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage #(
    parameter int FLUSH_CYCLES = 3
) (
    input  logic                CLK,
    input  logic                RST,

    input  logic                in_valid,
    output logic                in_ready,
    input  logic                mem_ready,

    input  exu_pkg::alu_op_t    alu_op,
    input  logic                op_32,
    input  exu_pkg::xword_t     a,
    input  exu_pkg::xword_t     b,
    input  exu_pkg::ctrl_kind_t ctrl_kind,
    input  exu_pkg::br_cond_t   br_cond,
    input  exu_pkg::xword_t     cmp1,
    input  exu_pkg::xword_t     cmp2,
    input  exu_pkg::xword_t     target_base,
    input  exu_pkg::xword_t     target_offset,
    input  exu_pkg::xword_t     pc,
    input  exu_pkg::xword_t     next_pc,
    input  exu_pkg::mem_op_t    mem_op_in,
    input  exu_pkg::mem_size_t  mem_size_in,

    output logic                out_valid,
    output exu_pkg::xword_t     wb_data,
    output exu_pkg::mem_op_t    mem_op,
    output exu_pkg::xword_t     mem_addr,
    output exu_pkg::mem_size_t  mem_size,
    output logic                ld_misaligned,
    output logic                st_misaligned,

    output logic                redirect,
    output exu_pkg::xword_t     redirect_pc,
    output logic                target_misaligned,
    output logic                flush
);
    import exu_pkg::*;

    logic   accept;
    xword_t alu_result;
    xword_t addr_calc;
    logic   ld_mis_calc;
    logic   st_mis_calc;

    redirect_if rd_bus ();

    // Memory stall freezes the whole stage
    assign in_ready = mem_ready;
    assign accept   = in_valid && mem_ready && !flush;

    ////////////////////////////////////////////////////
    // Execute units
    ////////////////////////////////////////////////////

    int_alu u_alu (
        .a      (a),
        .b      (b),
        .op     (alu_op),
        .op_32  (op_32),
        .result (alu_result)
    );

    branch_unit u_branch (
        .accept        (accept),
        .kind          (ctrl_kind),
        .cond          (br_cond),
        .cmp1          (cmp1),
        .cmp2          (cmp2),
        .target_base   (target_base),
        .target_offset (target_offset),
        .pc            (pc),
        .next_pc       (next_pc),
        .rd            (rd_bus.resolver)
    );

    mem_addr_check u_mem_addr (
        .a             (a),
        .b             (b),
        .op            (mem_op_in),
        .size          (mem_size_in),
        .addr          (addr_calc),
        .ld_misaligned (ld_mis_calc),
        .st_misaligned (st_mis_calc)
    );

    redirect_ctrl #(
        .FLUSH_CYCLES (FLUSH_CYCLES)
    ) u_redirect (
        .CLK               (CLK),
        .RST               (RST),
        .advance           (mem_ready),
        .rd                (rd_bus.controller),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .target_misaligned (target_misaligned),
        .flush             (flush)
    );

    ////////////////////////////////////////////////////
    // Result registers
    ////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            out_valid     <= 1'b0;
            mem_op        <= mem_none;
            ld_misaligned <= 1'b0;
            st_misaligned <= 1'b0;
        end
        else if (accept)
        begin
            out_valid     <= 1'b1;
            mem_op        <= mem_op_in;
            ld_misaligned <= ld_mis_calc;
            st_misaligned <= st_mis_calc;
        end
        else if (mem_ready)
        begin
            // Bubble or squashed instruction
            out_valid     <= 1'b0;
            mem_op        <= mem_none;
            ld_misaligned <= 1'b0;
            st_misaligned <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            wb_data  <= alu_result;
            mem_addr <= addr_calc;
            mem_size <= mem_size_in;
        end
    end

endmodule

// File: hw/exu_pkg.sv
package exu_pkg;

    ////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xword_t;

    ////////////////////////////////////////////////////
    // Operation encodings
    ////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_add     = 4'd0,
        alu_sub     = 4'd1,
        alu_sll     = 4'd2,
        alu_srl     = 4'd3,
        alu_sra     = 4'd4,
        alu_slt     = 4'd5,
        alu_sltu    = 4'd6,
        alu_xor     = 4'd7,
        alu_or      = 4'd8,
        alu_and     = 4'd9,
        alu_pass_a  = 4'd10,
        alu_pass_b  = 4'd11,
        alu_b_plus4 = 4'd12,
        alu_idle    = 4'd13
    } alu_op_t;

    // Same codes as funct3 of the branch instructions
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } br_cond_t;

    typedef enum logic [1:0] {
        ctrl_none   = 2'd0,
        ctrl_branch = 2'd1,
        ctrl_jump   = 2'd2
    } ctrl_kind_t;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_t;

    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } mem_size_t;

endpackage

// File: hw/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  exu_pkg::xword_t  a,
    input  exu_pkg::xword_t  b,
    input  exu_pkg::alu_op_t op,
    input  logic             op_32,
    output exu_pkg::xword_t  result
);
    import exu_pkg::*;

    xword_t      res_d;
    logic [31:0] res_w;
    logic        word_op;

    // 32-bit forms, b is the shifted and minuend operand
    always_comb
    begin
        case (op)
            alu_add: res_w = a[31:0] + b[31:0];
            alu_sub: res_w = b[31:0] - a[31:0];
            alu_sll: res_w = b[31:0] << a[4:0];
            alu_srl: res_w = b[31:0] >> a[4:0];
            alu_sra: res_w = $signed(b[31:0]) >>> a[4:0];
            default: res_w = '0;
        endcase
    end

    ////////////////////////////////////////////////////
    // Full width results
    ////////////////////////////////////////////////////

    always_comb
    begin
        case (op)
            alu_add:     res_d = a + b;
            alu_sub:     res_d = b - a;
            alu_sll:     res_d = b << a[5:0];
            alu_srl:     res_d = b >> a[5:0];
            alu_sra:     res_d = $signed(b) >>> a[5:0];
            alu_slt:     res_d = {{(XLEN-1){1'b0}}, $signed(b) < $signed(a)};
            alu_sltu:    res_d = {{(XLEN-1){1'b0}}, b < a};
            alu_xor:     res_d = a ^ b;
            alu_or:      res_d = a | b;
            alu_and:     res_d = a & b;
            alu_pass_a:  res_d = a;
            alu_pass_b:  res_d = b;
            alu_b_plus4: res_d = b + XLEN'(4);
            default:     res_d = '0;
        endcase
    end

    // W variants only exist for add, sub and shifts
    assign word_op = op_32 && (op inside {alu_add, alu_sub, alu_sll, alu_srl, alu_sra});

    assign result = word_op ? {{(XLEN-32){res_w[31]}}, res_w} : res_d;

endmodule

// File: hw/mem_addr_check.sv
`timescale 1ns/1ps

module mem_addr_check (
    input  exu_pkg::xword_t   a,
    input  exu_pkg::xword_t   b,
    input  exu_pkg::mem_op_t  op,
    input  exu_pkg::mem_size_t size,
    output exu_pkg::xword_t   addr,
    output logic              ld_misaligned,
    output logic              st_misaligned
);
    import exu_pkg::*;

    logic misaligned;

    assign addr = a + b;

    // Low address bits must be zero for the access width
    always_comb
    begin
        case (size)
            size_byte:   misaligned = 1'b0;
            size_half:   misaligned = addr[0];
            size_word:   misaligned = |addr[1:0];
            size_double: misaligned = |addr[2:0];
            default:     misaligned = 1'b0;
        endcase
    end

    assign ld_misaligned = misaligned && (op == mem_load);
    assign st_misaligned = misaligned && (op == mem_store);

endmodule

// File: hw/redirect_ctrl.sv
`timescale 1ns/1ps

module redirect_ctrl #(
    parameter int FLUSH_CYCLES = 3
) (
    input  logic             CLK,
    input  logic             RST,
    input  logic             advance,
    redirect_if.controller   rd,
    output logic             redirect,
    output exu_pkg::xword_t  redirect_pc,
    output logic             target_misaligned,
    output logic             flush
);

    localparam int CNT_W = $clog2(FLUSH_CYCLES + 1);

    logic [CNT_W-1:0] flush_cnt;
    logic             take;

    // Squashed instructions never redirect
    assign take = rd.resolve && rd.mispredict && !flush;

    ////////////////////////////////////////////////////
    // Redirect pulse and flush window
    ////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            redirect          <= 1'b0;
            target_misaligned <= 1'b0;
            flush_cnt         <= '0;
        end
        else if (advance)
        begin
            redirect <= take;
            if (take)
            begin
                flush_cnt         <= CNT_W'(FLUSH_CYCLES);
                target_misaligned <= rd.target_misaligned;
            end
            else if (flush_cnt != '0)
            begin
                flush_cnt <= flush_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (advance && take)
        begin
            redirect_pc <= rd.new_pc;
        end
    end

    assign flush = flush_cnt != '0;

endmodule

// File: hw/redirect_if.sv
`timescale 1ns/1ps

interface redirect_if;
    import exu_pkg::*;

    logic   resolve;
    logic   mispredict;
    xword_t new_pc;
    logic   target_misaligned;

    // Values only meaningful while resolve is high
    modport resolver (
        output resolve,
        output mispredict,
        output new_pc,
        output target_misaligned
    );

    modport controller (
        input resolve,
        input mispredict,
        input new_pc,
        input target_misaligned
    );

endinterface

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_ex_stage -o sim_tb --Mdir obj_dir
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

// File: src.f
hw/exu_pkg.sv
hw/redirect_if.sv
hw/int_alu.sv
hw/branch_unit.sv
hw/mem_addr_check.sv
hw/redirect_ctrl.sv
hw/ex_stage.sv
bench/tb_clock.sv
bench/tb_ex_stage.sv
